/* frontend_top.f */
+incdir+src
src/frontend_pkg.sv
src/pc_gen.sv
src/instr_mem.sv
src/fetch_queue.sv
src/predecode.sv
src/frontend_top.sv
tests/frontend_tb.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench.

VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= frontend_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Everything OK

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell sed -n '/^[^+]/p' $(FILELIST)) src/frontend_defines.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run fails unless the pass message shows up in the output.
run: $(SIM_BIN)
	./$(SIM_BIN) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)

/* tests/frontend_testdata.txt */
// program block: count, then one line per word: instr class imm (all hex).
// redirect block: count, then kind after jump_base jump_offset branch_base branch_offset.
// kind 1 jump, 2 taken branch, 3 not-taken branch, 4 jump and branch together.
// last word: total number of transfers to check.
00000014
003100B3 0 00000000 // add x1,x2,x3
00500093 1 00000005 // addi x1,x0,5
FFF08113 1 FFFFFFFF // addi x2,x1,-1
00812183 2 00000008 // lw x3,8(x2)
FFC0A203 2 FFFFFFFC // lw x4,-4(x1)
00512623 3 0000000C // sw x5,12(x2)
FE60AC23 3 FFFFFFF8 // sw x6,-8(x1)
00208863 4 00000010 // beq x1,x2,+16
FE019CE3 4 FFFFFFF8 // bne x3,x0,-8
001000EF 5 00000800 // jal x1,+2048
FFDFF06F 5 FFFFFFFC // jal x0,-4
00008067 6 00000000 // jalr x0,0(x1)
FF0280E7 6 FFFFFFF0 // jalr x1,-16(x5)
123452B7 7 12345000 // lui x5,0x12345
FFFFF317 7 FFFFF000 // auipc x6,0xfffff
FFFFFFFF 8 00000000 // opcode 1111111
0062C3B3 0 00000000 // xor x7,x5,x6
7FF12413 1 000007FF // slti x8,x2,2047
402084B3 0 00000000 // sub x9,x1,x2
00000000 8 00000000 // all zero word
00000006
1 00000018 00000040 FFFFFFC0 00000000 00000000 // jump back to 0
3 00000028 00000000 00000000 00000200 00000000 // branch not taken
2 00000032 00000000 00000000 00000010 00000008 // branch to 0x18
4 00000046 00000080 00000020 00000000 00000004 // jump to 0xa0 wins
1 0000005A 00000300 FFFFFD08 00000000 00000000 // jump to 0x8
2 00000064 00000000 00000000 00000020 00000010 // branch to 0x30
000000A0

/* tests/frontend_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "frontend_defines.svh"

module frontend_tb
    import frontend_pkg::*;
();

    localparam int IDX_W   = $clog2(`IMEM_WORDS);
    localparam int TIMEOUT = 2000;

    logic clk;
    logic rst;
    logic jump_valid;
    pc_t  jump_base;
    imm_t jump_offset;
    logic branch_valid;
    logic branch_taken;
    pc_t  branch_base;
    imm_t branch_offset;
    logic load_en;
    pc_t  load_addr;
    logic [`XLEN-1:0] load_data;
    logic out_ready;
    logic out_valid;
    pc_t  out_pc;
    logic [`XLEN-1:0] out_instr;
    epoch_t out_epoch;
    instr_class_t out_class;
    imm_t out_imm;

    logic [31:0]      tdata [0:511];
    logic [`XLEN-1:0] image [`IMEM_WORDS];
    instr_class_t     exp_class [`IMEM_WORDS];
    imm_t             exp_imm [`IMEM_WORDS];
    logic [31:0]      cmd [0:15][0:5];
    int               cmd_count;
    int               total;

    integer seed = 20136;
    int     xfer_count = 0;
    logic   loaded = 1'b0;
    pc_t    exp_pc = `RESET_PC;
    epoch_t exp_epoch = '0;

    frontend_top i_frontend_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // error handling and typed compares.
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: out_pc got %h expected %h", $time, got, exp);
            abort_run("pc mismatch");
        end
    endtask

    task automatic check_instr(input instr_u got, input instr_u exp);
        if (got !== exp) begin
            $display("FAILED at %0t: out_instr got %h expected %h", $time, got, exp);
            abort_run("instruction mismatch");
        end
    endtask

    task automatic check_epoch(input epoch_t got, input epoch_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: out_epoch got %h expected %h", $time, got, exp);
            abort_run("epoch mismatch");
        end
    endtask

    task automatic check_class(input instr_class_t got, input instr_class_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: out_class got %0d expected %0d", $time, got, exp);
            abort_run("class mismatch");
        end
    endtask

    task automatic check_imm(input imm_t got, input imm_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: out_imm got %h expected %h", $time, got, exp);
            abort_run("immediate mismatch");
        end
    endtask

    // --------------------------------------------------
    // stimulus file and memory image.
    // --------------------------------------------------
    task automatic read_testdata();
        int n;
        int p;
        $readmemh("tests/frontend_testdata.txt", tdata);
        if ($isunknown(tdata[0])) abort_run("test data file could not be read");
        n = int'(tdata[0]);
        p = 1;
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            if (i < n) begin
                image[i]     = tdata[p];
                exp_class[i] = instr_class_t'(tdata[p+1][3:0]);
                exp_imm[i]   = tdata[p+2];
                p += 3;
            end else begin
                // addi x0,x0,index, so each fill word is unique.
                image[i]     = {12'(i), 20'h00013};
                exp_class[i] = cls_alu_imm;
                exp_imm[i]   = imm_t'(i);
            end
        end
        cmd_count = int'(tdata[p]);
        p++;
        for (int c = 0; c < cmd_count; c++) begin
            for (int f = 0; f < 6; f++) cmd[c][f] = tdata[p+f];
            p += 6;
        end
        total = int'(tdata[p]);
    endtask

    task automatic wait_transfers(input int target);
        int cycles;
        cycles = 0;
        while (xfer_count < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) abort_run("timeout waiting for output transfers");
        end
    endtask

    task automatic issue_redirect(input int c);
        logic [31:0] kind;
        kind = cmd[c][0];
        @(posedge clk);
        if (kind == 1 || kind == 4) begin
            jump_valid  <= 1'b1;
            jump_base   <= cmd[c][2];
            jump_offset <= cmd[c][3];
        end
        if (kind != 1) begin
            branch_valid  <= 1'b1;
            branch_taken  <= (kind != 3);
            branch_base   <= cmd[c][4];
            branch_offset <= cmd[c][5];
        end
        @(posedge clk);
        jump_valid   <= 1'b0;
        branch_valid <= 1'b0;
        branch_taken <= 1'b0;
        // redirect lands on this edge.
        if (kind != 3) begin
            exp_epoch = exp_epoch + epoch_t'(1);
            exp_pc    = (kind == 2) ? cmd[c][4] + cmd[c][5] : cmd[c][2] + cmd[c][3];
        end
    endtask

    // a transfer is decided at the next rising edge.
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            check_epoch(out_epoch, exp_epoch);
            check_pc(out_pc, exp_pc);
            check_instr(instr_u'(out_instr), instr_u'(image[exp_pc[IDX_W+1:2]]));
            check_class(out_class, exp_class[exp_pc[IDX_W+1:2]]);
            check_imm(out_imm, exp_imm[exp_pc[IDX_W+1:2]]);
            exp_pc = exp_pc + 32'd4;
            xfer_count++;
        end
    end

    always @(posedge clk) begin
        if (loaded) out_ready <= ($random(seed) & 3) != 0;
    end

    initial begin
        rst = 1'b1;
        jump_valid = 1'b0;
        jump_base = '0;
        jump_offset = '0;
        branch_valid = 1'b0;
        branch_taken = 1'b0;
        branch_base = '0;
        branch_offset = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        out_ready = 1'b0;
        read_testdata();

        // reset drops after 5 cycles, the load stays ahead of the stalled fetch.
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= pc_t'(i * 4);
            load_data <= image[i];
            if (i == 4) rst <= 1'b0;
        end
        @(posedge clk);
        load_en <= 1'b0;
        loaded  <= 1'b1;

        for (int c = 0; c < cmd_count; c++) begin
            wait_transfers(int'(cmd[c][1]));
            issue_redirect(c);
        end
        wait_transfers(total);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* src/frontend_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "frontend_defines.svh"

module frontend_top
    import frontend_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,

    input  wire logic             jump_valid,
    input  wire pc_t              jump_base,
    input  wire imm_t             jump_offset,
    input  wire logic             branch_valid,
    input  wire logic             branch_taken,
    input  wire pc_t              branch_base,
    input  wire imm_t             branch_offset,

    input  wire logic             load_en,
    input  wire pc_t              load_addr,
    input  wire logic [`XLEN-1:0] load_data,

    input  wire logic             out_ready,
    output logic                  out_valid,
    output pc_t                   out_pc,
    output logic [`XLEN-1:0]      out_instr,
    output epoch_t                out_epoch,
    output instr_class_t          out_class,
    output imm_t                  out_imm
);

    logic             fetch_enable;
    logic             req_valid;
    pc_t              req_addr;
    epoch_t           cur_epoch;
    logic             rsp_valid;
    logic [`XLEN-1:0] rsp_data;
    instr_u           head_instr;

    pc_gen i_pc_gen (
        .clk, .rst, .fetch_enable,
        .jump_valid, .jump_base, .jump_offset,
        .branch_valid, .branch_taken, .branch_base, .branch_offset,
        .req_valid, .req_addr, .cur_epoch
    );

    instr_mem i_instr_mem (
        .clk, .rst, .req_valid, .req_addr,
        .load_en, .load_addr, .load_data,
        .rsp_valid, .rsp_data
    );

    // request tag takes the epoch current at issue.
    fetch_queue i_fetch_queue (
        .clk, .rst, .req_valid, .req_addr,
        .req_epoch (cur_epoch),
        .cur_epoch,
        .rsp_valid, .rsp_data,
        .out_ready, .fetch_enable,
        .out_valid, .out_pc, .out_instr, .out_epoch, .head_instr
    );

    predecode i_predecode (
        .head_instr,
        .cls (out_class),
        .imm (out_imm)
    );

endmodule

`default_nettype wire

/* src/predecode.sv */
`timescale 1ns/1ns
`default_nettype none

module predecode
    import frontend_pkg::*;
(
    input  wire instr_u  head_instr,
    output instr_class_t cls,
    output imm_t         imm
);

    // --------------------------------------------------
    // rv32i major opcodes.
    // --------------------------------------------------
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    imm_t imm_i;
    imm_t imm_s;
    imm_t imm_b;
    imm_t imm_u;
    imm_t imm_j;

    assign imm_i = {{20{head_instr.i_fmt.imm_11_0[11]}}, head_instr.i_fmt.imm_11_0};
    assign imm_s = {{20{head_instr.s_fmt.imm_11_5[6]}}, head_instr.s_fmt.imm_11_5,
                    head_instr.s_fmt.imm_4_0};
    assign imm_b = {{19{head_instr.b_fmt.imm_12}}, head_instr.b_fmt.imm_12,
                    head_instr.b_fmt.imm_11, head_instr.b_fmt.imm_10_5,
                    head_instr.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {head_instr.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{head_instr.j_fmt.imm_20}}, head_instr.j_fmt.imm_20,
                    head_instr.j_fmt.imm_19_12, head_instr.j_fmt.imm_11,
                    head_instr.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        cls = cls_illegal;
        imm = '0;               // r-type and unknown.
        unique case (head_instr.r_fmt.opcode)
            OP_REG: cls = cls_alu;
            OP_IMM: begin
                cls = cls_alu_imm;
                imm = imm_i;
            end
            OP_LOAD: begin
                cls = cls_load;
                imm = imm_i;
            end
            OP_STORE: begin
                cls = cls_store;
                imm = imm_s;
            end
            OP_BRANCH: begin
                cls = cls_branch;
                imm = imm_b;
            end
            OP_JAL: begin
                cls = cls_jal;
                imm = imm_j;
            end
            OP_JALR: begin
                cls = cls_jalr;
                imm = imm_i;
            end
            OP_LUI, OP_AUIPC: begin
                cls = cls_upper;
                imm = imm_u;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* src/fetch_queue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "frontend_defines.svh"

module fetch_queue
    import frontend_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,

    input  wire logic             req_valid,
    input  wire pc_t              req_addr,
    input  wire epoch_t           req_epoch,
    input  wire epoch_t           cur_epoch,

    input  wire logic             rsp_valid,
    input  wire logic [`XLEN-1:0] rsp_data,

    input  wire logic             out_ready,
    output logic                  fetch_enable,
    output logic                  out_valid,
    output pc_t                   out_pc,
    output logic [`XLEN-1:0]      out_instr,
    output epoch_t                out_epoch,
    output instr_u                head_instr
);

    localparam int PTR_W = $clog2(`FQ_DEPTH);
    localparam int CNT_W = $clog2(`FQ_DEPTH + 1);

    logic             inflight;     // a response arrives this cycle.
    pc_t              tag_pc;
    epoch_t           tag_epoch;

    pc_t              ent_pc    [`FQ_DEPTH];
    logic [`XLEN-1:0] ent_instr [`FQ_DEPTH];
    epoch_t           ent_epoch [`FQ_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;
    logic flush;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`FQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // --------------------------------------------------
    // head, stale entries are never shown.
    // --------------------------------------------------
    assign out_pc     = ent_pc[rd_ptr];
    assign out_instr  = ent_instr[rd_ptr];
    assign out_epoch  = ent_epoch[rd_ptr];
    assign head_instr = ent_instr[rd_ptr];

    assign out_valid = (count != '0) && (ent_epoch[rd_ptr] == cur_epoch);
    assign flush     = (count != '0) && (ent_epoch[rd_ptr] != cur_epoch);
    assign push      = rsp_valid && (tag_epoch == cur_epoch);
    assign pop       = out_valid && out_ready;

    // reserve a slot for the word still in flight.
    assign fetch_enable = (int'(count) + int'(inflight)) < `FQ_DEPTH;

    always_ff @(posedge clk) begin
        if (req_valid) begin
            tag_pc    <= req_addr;
            tag_epoch <= req_epoch;
        end
        if (push) begin
            ent_pc[wr_ptr]    <= tag_pc;
            ent_instr[wr_ptr] <= rsp_data;
            ent_epoch[wr_ptr] <= tag_epoch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= 1'b0;
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
        end else begin
            inflight <= req_valid;
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (flush) begin
                // everything queued predates the redirect.
                rd_ptr <= wr_ptr;
                count  <= CNT_W'(push);
            end else begin
                if (pop) rd_ptr <= ptr_next(rd_ptr);
                count <= count + CNT_W'(push) - CNT_W'(pop);
            end
        end
    end

endmodule

`default_nettype wire

/* src/instr_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "frontend_defines.svh"

module instr_mem
    import frontend_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,

    input  wire logic             req_valid,
    input  wire pc_t              req_addr,

    // byte address, low two bits ignored.
    input  wire logic             load_en,
    input  wire pc_t              load_addr,
    input  wire logic [`XLEN-1:0] load_data,

    output logic                  rsp_valid,
    output logic [`XLEN-1:0]      rsp_data
);

    localparam int IDX_W = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0] mem [`IMEM_WORDS];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[IDX_W+1:2]] <= load_data;
        end
    end

    // one cycle read.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp_data <= mem[req_addr[IDX_W+1:2]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) rsp_valid <= 1'b0;
        else     rsp_valid <= req_valid;
    end

endmodule

`default_nettype wire

/* src/pc_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "frontend_defines.svh"

module pc_gen
    import frontend_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   fetch_enable,

    input  wire logic   jump_valid,
    input  wire pc_t    jump_base,
    input  wire imm_t   jump_offset,

    input  wire logic   branch_valid,
    input  wire logic   branch_taken,
    input  wire pc_t    branch_base,
    input  wire imm_t   branch_offset,

    output logic        req_valid,
    output pc_t         req_addr,
    output epoch_t      cur_epoch
);

    logic   started;    // low for the first cycle out of reset.
    pc_t    pc;
    epoch_t epoch;

    pc_t    next_base;
    imm_t   next_step;
    epoch_t next_epoch;

    assign req_valid = started && fetch_enable;
    assign req_addr  = pc;
    assign cur_epoch = epoch;

    // --------------------------------------------------
    // next address is always base + step.
    // --------------------------------------------------
    always_comb begin
        next_base  = pc;
        next_step  = '0;           // hold while stalled.
        next_epoch = epoch;

        if (req_valid) begin
            next_step = imm_t'(4);
        end

        // jump wins over a branch in the same cycle.
        if (jump_valid) begin
            next_base  = jump_base;
            next_step  = jump_offset;
            next_epoch = epoch + 1'b1;
        end else if (branch_valid && branch_taken) begin
            next_base  = branch_base;
            next_step  = branch_offset;
            next_epoch = epoch + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            pc      <= `RESET_PC;
            epoch   <= '0;
        end else begin
            started <= 1'b1;
            pc      <= next_base + next_step;
            epoch   <= next_epoch;
        end
    end

endmodule

`default_nettype wire

/* src/frontend_pkg.sv */
`default_nettype none

`include "frontend_defines.svh"

package frontend_pkg;

    typedef logic [`XLEN-1:0]    pc_t;
    typedef logic [`EPOCH_W-1:0] epoch_t;
    typedef logic [`XLEN-1:0]    imm_t;

    // 9 classes, so one bit wider than a 3-bit code.
    typedef enum logic [3:0] {
        cls_alu,
        cls_alu_imm,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_upper,
        cls_illegal
    } instr_class_t;

    // --------------------------------------------------
    // rv32 instruction formats, msb first.
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

`default_nettype wire

/* src/frontend_defines.svh */
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// datapath and address width.
`define XLEN 32

// redirect generation counter, wraps.
`define EPOCH_W 2

// fetch queue entries.
`define FQ_DEPTH 4

// instruction memory size in 32-bit words.
`define IMEM_WORDS 256

`define RESET_PC 32'h0000_0000

`endif
